/* hw/br_pkg.sv */
`default_nettype none

package br_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [3:0]  br_kind_t;
    typedef logic [4:0]  br_sub_t;
    typedef logic [31:0] ctrl_t;

    // instruction classes, low nibble of ctrl
    localparam br_kind_t KIND_BR  = 4'd1;
    localparam br_kind_t KIND_JMP = 4'd8;

    // conditional branch subtypes
    localparam br_sub_t SUB_ALWAYS = 5'd0;
    localparam br_sub_t SUB_EQ     = 5'd1;
    localparam br_sub_t SUB_NE     = 5'd2;
    localparam br_sub_t SUB_LT     = 5'd3;
    localparam br_sub_t SUB_GE     = 5'd4;
    localparam br_sub_t SUB_LTU    = 5'd5;
    localparam br_sub_t SUB_GEU    = 5'd6;

    // jump subtypes
    localparam br_sub_t SUB_JR  = 5'd0;
    localparam br_sub_t SUB_JPC = 5'd1;

    // flag bits in ctrl
    localparam int CTRL_BR_BIT   = 31;
    localparam int CTRL_PAIR_BIT = 30;

    // result queue, also the upstream credit count
    localparam int RES_DEPTH   = 4;
    localparam int RES_PTR_W   = $clog2(RES_DEPTH);
    localparam int RES_CNT_W   = $clog2(RES_DEPTH + 1);
    // downstream buffer slots
    localparam int OUT_CREDITS = 2;
    localparam int OCRED_W     = $clog2(OUT_CREDITS + 1);

    // fetch block is 8 bytes
    localparam int    FETCH_ALIGN = 3;
    localparam word_t FETCH_BYTES = word_t'(2 ** FETCH_ALIGN);
    localparam word_t FETCH_MASK  = ~(FETCH_BYTES - word_t'(1));

    typedef logic [RES_PTR_W-1:0] res_ptr_t;
    typedef logic [RES_CNT_W-1:0] res_cnt_t;
    typedef logic [OCRED_W-1:0]   ocred_t;

    // predictor record, 32 bits
    typedef struct packed {
        logic        hit;
        logic        taken;
        logic [29:0] spare;
    } pred_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t imm;
        word_t rj;
        word_t rk;
        word_t npc;
        pred_t pred;
    } br_req_t;

    typedef struct packed {
        logic  redirect;
        logic  flush_pair;
        word_t target;
        word_t pc;
    } br_res_t;

    // field pickers for the control word
    function automatic br_kind_t ctrl_kind(ctrl_t c);
        return c[3:0];
    endfunction

    function automatic br_sub_t ctrl_sub(ctrl_t c);
        return c[11:7];
    endfunction

endpackage

`default_nettype wire

/* hw/br_cond_eval.sv */
`timescale 1ns/10ps
`default_nettype none

module br_cond_eval import br_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  br_req_t in_req,
    output logic    taken_valid,
    output logic    taken
);

    br_kind_t kind;
    br_sub_t  sub;
    logic     op_eq;
    logic     op_lt;
    logic     op_ltu;
    logic     taken_d;

    assign kind = ctrl_kind(in_req.ctrl);
    assign sub  = ctrl_sub(in_req.ctrl);

    // compare operands here, no external zero flag
    assign op_eq  = (in_req.rj == in_req.rk);
    assign op_lt  = ($signed(in_req.rj) < $signed(in_req.rk));
    assign op_ltu = (in_req.rj < in_req.rk);

    always_comb begin
        // unknown kind or subtype falls through
        taken_d = 1'b0;
        if (kind == KIND_BR) begin
            case (sub)
                SUB_ALWAYS: taken_d = 1'b1;
                SUB_EQ:     taken_d = op_eq;
                SUB_NE:     taken_d = !op_eq;
                SUB_LT:     taken_d = op_lt;
                SUB_GE:     taken_d = !op_lt;
                SUB_LTU:    taken_d = op_ltu;
                SUB_GEU:    taken_d = !op_ltu;
                default:    taken_d = 1'b0;
            endcase
        end else if (kind == KIND_JMP) begin
            // both jump forms are unconditional
            taken_d = (sub == SUB_JR) || (sub == SUB_JPC);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            taken_valid <= 1'b0;
        end else begin
            taken_valid <= in_valid;
        end
    end

    // result bit only moves with a request
    always_ff @(posedge clk) begin
        if (in_valid) begin
            taken <= taken_d;
        end
    end

endmodule

`default_nettype wire

/* hw/br_target_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module br_target_gen import br_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  br_req_t in_req,
    output logic    tgt_valid,
    output word_t   taken_target,
    output word_t   fall_target,
    output br_req_t fwd_req
);

    logic  is_jr;
    word_t base;
    word_t taken_d;
    word_t fall_d;

    // register-indirect jump uses rj as base
    assign is_jr = (ctrl_kind(in_req.ctrl) == KIND_JMP) && (ctrl_sub(in_req.ctrl) == SUB_JR);
    assign base  = is_jr ? in_req.rj : in_req.pc;

    assign taken_d = base + in_req.imm;

    // next aligned fetch block
    assign fall_d = (in_req.pc & FETCH_MASK) + FETCH_BYTES;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tgt_valid <= 1'b0;
        end else begin
            tgt_valid <= in_valid;
        end
    end

    // payload, held alongside the valid bit
    always_ff @(posedge clk) begin
        if (in_valid) begin
            taken_target <= taken_d;
            fall_target  <= fall_d;
            fwd_req      <= in_req;
        end
    end

endmodule

`default_nettype wire

/* hw/br_resolver.sv */
`timescale 1ns/10ps
`default_nettype none

module br_resolver import br_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    taken_valid,
    input  logic    taken,
    input  logic    tgt_valid,
    input  word_t   taken_target,
    input  word_t   fall_target,
    input  br_req_t fwd_req,
    input  logic    out_credit,
    output logic    out_valid,
    output br_res_t out_res,
    output logic    in_credit
);

    word_t    res_target;
    logic     is_br;
    logic     is_pair;
    logic     npc_match;
    logic     res_redirect;
    logic     res_flush;
    br_res_t  res_d;
    logic     push;
    logic     pop;

    br_res_t  res_mem [RES_DEPTH];
    res_ptr_t wr_ptr;
    res_ptr_t rd_ptr;
    res_cnt_t res_cnt;
    ocred_t   out_cred;

    // both units see the same request, so valids line up
    assign push = taken_valid && tgt_valid;

    assign res_target = taken ? taken_target : fall_target;

    assign is_br     = fwd_req.ctrl[CTRL_BR_BIT];
    assign is_pair   = fwd_req.ctrl[CTRL_PAIR_BIT];
    assign npc_match = (fwd_req.npc == res_target);

    // fetch went elsewhere
    assign res_redirect = is_br && !npc_match;

    // predictor right, but partner slot of the block must go
    // only for the first slot of the block, pc bit 3 clear
    assign res_flush = npc_match && !fwd_req.pc[3] && fwd_req.pred.hit &&
                       fwd_req.pred.taken && is_pair && is_br;

    always_comb begin
        res_d            = '0;
        res_d.redirect   = res_redirect;
        res_d.flush_pair = res_flush;
        res_d.target     = res_target;
        res_d.pc         = fwd_req.pc;
    end

    // send head only while downstream holds a slot
    assign out_valid = (res_cnt != '0) && (out_cred != '0);
    assign pop       = out_valid;
    assign out_res   = res_mem[rd_ptr];
    // each send frees one upstream slot
    assign in_credit = pop;

    // queue storage
    always_ff @(posedge clk) begin
        if (push) begin
            res_mem[wr_ptr] <= res_d;
        end
    end

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_cnt <= '0;
        end else begin
            case ({push, pop})
                2'b10:   res_cnt <= res_cnt + 1'b1;
                2'b01:   res_cnt <= res_cnt - 1'b1;
                default: res_cnt <= res_cnt;
            endcase
        end
    end

    // downstream credits, one per free slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_cred <= ocred_t'(OUT_CREDITS);
        end else begin
            case ({pop, out_credit})
                2'b10:   out_cred <= out_cred - 1'b1;
                2'b01:   out_cred <= out_cred + 1'b1;
                default: out_cred <= out_cred;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/br_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module br_unit import br_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    // upstream side
    input  logic    in_valid,
    input  br_req_t in_req,
    output logic    in_credit,
    // downstream side
    output logic    out_valid,
    output br_res_t out_res,
    input  logic    out_credit
);

    // evaluator to resolver
    logic    taken_valid;
    logic    taken;

    // target generator to resolver
    logic    tgt_valid;
    word_t   taken_target;
    word_t   fall_target;
    br_req_t fwd_req;

    // taken decision, one cycle
    br_cond_eval cond_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .taken_valid (taken_valid),
        .taken       (taken)
    );

    // both candidate targets, same cycle as the evaluator
    br_target_gen tgt_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_req       (in_req),
        .tgt_valid    (tgt_valid),
        .taken_target (taken_target),
        .fall_target  (fall_target),
        .fwd_req      (fwd_req)
    );

    // redirect and flush, result queue, credits
    br_resolver res_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .taken_valid  (taken_valid),
        .taken        (taken),
        .tgt_valid    (tgt_valid),
        .taken_target (taken_target),
        .fall_target  (fall_target),
        .fwd_req      (fwd_req),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_res      (out_res),
        .in_credit    (in_credit)
    );

endmodule

`default_nettype wire

/* sim/br_unit_props.sv */
`timescale 1ns/10ps
`default_nettype none

module br_unit_props import br_pkg::*; (
    input logic     clk,
    input logic     arst_n,
    input logic     out_valid,
    input logic     in_credit,
    input logic     out_credit,
    input logic     push,
    input logic     pop,
    input res_cnt_t res_cnt,
    input ocred_t   out_cred
);

    // with no credit left and none returned nothing goes out next
    send_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        ((out_cred == '0) && !out_credit) |=> !out_valid)
        else $error("out_valid after the downstream credit count ran out");

    // a push without a pop needs room in the queue
    queue_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        (push && !pop) |-> (res_cnt != res_cnt_t'(RES_DEPTH)))
        else $error("result queue written while full");

    // checked from the cycle after reset is seen low
    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |=> (!in_credit && !out_valid))
        else $error("in_credit or out_valid high during reset");

endmodule

bind br_resolver br_unit_props props_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_valid  (out_valid),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .push       (push),
    .pop        (pop),
    .res_cnt    (res_cnt),
    .out_cred   (out_cred)
);

`default_nettype wire

/* sim/br_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module br_unit_tb import br_pkg::*; ();

    localparam int MAX_VEC = 64;

    logic    clk        = 1'b0;
    logic    arst_n     = 1'b0;
    logic    in_valid   = 1'b0;
    br_req_t in_req     = '0;
    logic    out_credit = 1'b0;
    logic    in_credit;
    logic    out_valid;
    br_res_t out_res;

    // vectors and expected results from the data file
    br_req_t stim [MAX_VEC];
    br_res_t expd [MAX_VEC];
    int      n_vec = 0;

    int      tx_idx        = 0;
    int      rx_idx        = 0;
    int      up_cred       = RES_DEPTH;
    // slots held by the downstream model
    int      held          = 0;
    int      delay         = 0;
    int      credit_pulses = 0;
    int      cmp_errors    = 0;
    int      end_errors    = 0;
    int      cycles        = 0;
    int      cycle_limit   = 100;
    integer  seed          = 91;

    br_unit dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_credit (out_credit)
    );

    always #50 clk = ~clk;

    task automatic load_vectors();
        int    fd;
        int    cnt;
        string line;
        word_t ctrl, pc, imm, rj, rk;
        word_t npc, pred, rdir, flsh, tgt;
        fd = $fopen("sim/br_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/br_testdata.txt");
            end_errors++;
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                cnt = $fgets(line, fd);
                // skip blank lines and comments
                if (cnt > 1 && line.substr(0, 0) != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                  ctrl, pc, imm, rj, rk, npc, pred, rdir, flsh, tgt);
                    if (cnt != 10) begin
                        $display("malformed vector line: %s", line);
                        end_errors++;
                    end else begin
                        stim[n_vec].ctrl       = ctrl;
                        stim[n_vec].pc         = pc;
                        stim[n_vec].imm        = imm;
                        stim[n_vec].rj         = rj;
                        stim[n_vec].rk         = rk;
                        stim[n_vec].npc        = npc;
                        stim[n_vec].pred       = pred_t'(pred);
                        expd[n_vec].redirect   = rdir[0];
                        expd[n_vec].flush_pair = flsh[0];
                        expd[n_vec].target     = tgt;
                        expd[n_vec].pc         = pc;
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // results must come back in input order
    task automatic check_result(br_res_t got);
        br_res_t want;
        if (rx_idx >= n_vec) begin
            $display("DUT sent a result with pc %h after all vectors were answered", got.pc);
            cmp_errors++;
        end else begin
            want = expd[rx_idx];
            if (got.pc != want.pc) begin
                $display("** Error at %0d ns: vector %0d pc %h expected %h",
                         $time, rx_idx, got.pc, want.pc);
                cmp_errors++;
            end
            if (got.redirect != want.redirect) begin
                $display("** Error at %0d ns: vector %0d redirect %0b expected %0b",
                         $time, rx_idx, got.redirect, want.redirect);
                cmp_errors++;
            end
            if (got.flush_pair != want.flush_pair) begin
                $display("** Error at %0d ns: vector %0d flush_pair %0b expected %0b",
                         $time, rx_idx, got.flush_pair, want.flush_pair);
                cmp_errors++;
            end
            if (got.target != want.target) begin
                $display("** Error at %0d ns: vector %0d target %h expected %h",
                         $time, rx_idx, got.target, want.target);
                cmp_errors++;
            end
        end
        rx_idx++;
    endtask

    // upstream side, one request per cycle while a credit is held
    always @(posedge clk) begin
        if (!arst_n) begin
            in_valid <= 1'b0;
        end else begin
            if (in_credit) begin
                up_cred++;
            end
            in_valid <= 1'b0;
            if (tx_idx < n_vec && up_cred > 0) begin
                in_valid <= 1'b1;
                in_req   <= stim[tx_idx];
                tx_idx++;
                up_cred--;
            end
        end
    end

    // downstream model with random slot return
    always @(posedge clk) begin
        if (!arst_n) begin
            out_credit <= 1'b0;
        end else begin
            if (in_credit) begin
                credit_pulses++;
            end
            if (out_valid) begin
                check_result(out_res);
                held++;
            end
            out_credit <= 1'b0;
            if (held > 0) begin
                if (delay == 0) begin
                    out_credit <= 1'b1;
                    held--;
                    delay = $random(seed) & 7;
                end else begin
                    delay--;
                end
            end
        end
    end

    // cycle count, reset release after 4 edges, run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles == 4) begin
            arst_n <= 1'b1;
        end
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d results", cycles, rx_idx, n_vec);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        load_vectors();
        cycle_limit = 40 * n_vec + 100;
        if (n_vec == 0) begin
            $display("no vectors were loaded");
            end_errors++;
        end
        // all results back, then a quiet window to catch strays
        wait (rx_idx == n_vec);
        repeat (10) @(posedge clk);
        if (credit_pulses != rx_idx) begin
            $display("** Error at %0d ns: %0d in_credit pulses for %0d results",
                     $time, credit_pulses, rx_idx);
            end_errors++;
        end
        $display("results %0d of %0d, compare errors %0d, other errors %0d",
                 rx_idx, n_vec, cmp_errors, end_errors);
        if (cmp_errors == 0 && end_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/br_testdata.txt */
# columns in hex: ctrl pc imm rj rk npc pred
# then expected redirect flush_pair target
80000001 00001000 00000040 00000000 00000000 00001040 00000000 0 0 00001040
80000081 00001004 00000100 12345678 12345678 00001008 00000000 1 0 00001104
80000081 00001010 00000100 00000001 00000002 00001018 00000000 0 0 00001018
80000101 00002000 fffffff0 00000005 00000006 00002008 00000000 1 0 00001ff0
80000101 00002006 00000010 00000007 00000007 00002008 00000000 0 0 00002008
80000181 00003000 00000020 ffffffff 00000001 00003020 00000000 0 0 00003020
80000181 00003008 00000020 7fffffff 80000000 00003028 00000000 1 0 00003010
80000201 00003010 00000040 80000000 7fffffff 00003018 00000000 0 0 00003018
80000201 0000301c 00000100 80000000 80000000 00003020 00000000 1 0 0000311c
80000281 00004000 00000080 ffffffff 00000001 00004008 00000000 0 0 00004008
80000281 00004008 00000080 00000001 ffffffff 00004088 00000000 0 0 00004088
80000301 00004010 00000080 00000000 00000001 00004090 00000000 1 0 00004018
80000301 00004014 ffffff00 ffffffff ffffffff 00003f14 00000000 0 0 00003f14
80000008 00005000 00000004 00008000 00000000 00005008 00000000 1 0 00008004
80000088 00005004 00000200 00008000 00000000 00005204 00000000 0 0 00005204
80000002 00005010 00000100 00000000 00000000 00005110 00000000 1 0 00005018
80000381 00005020 00000100 00000001 00000001 00005028 00000000 0 0 00005028
80000108 00005030 00000100 00009000 00000000 00005038 00000000 0 0 00005038
00000081 00006000 00000040 00000003 00000003 00006008 00000000 0 0 00006040
40000001 00006010 00000040 00000000 00000000 00006050 c0000000 0 0 00006050
c0000001 00007000 00000100 00000000 00000000 00007100 c0000000 0 1 00007100
c0000001 00007008 00000100 00000000 00000000 00007108 c0000000 0 0 00007108
c0000001 00007010 00000100 00000000 00000000 00007110 40000000 0 0 00007110
c0000001 00007020 00000100 00000000 00000000 00007120 80000000 0 0 00007120
80000001 00007030 00000100 00000000 00000000 00007130 c0000000 0 0 00007130
c0000001 00007040 00000100 00000000 00000000 00007048 c0000000 1 0 00007140
c0000081 00007050 00000100 00000001 00000002 00007058 c0000000 0 1 00007058
c0000008 00007060 00000010 0000a000 00000000 0000a010 c0000000 0 1 0000a010
c0000101 00007064 0000001c 00000001 00000002 00007080 c00abcde 0 1 00007080
80000081 fffffffc 00000010 00000001 00000002 00000000 00000000 0 0 00000000
80000181 00008000 00000040 80000000 80000000 00008040 00000000 1 0 00008008
80000281 00008008 00000040 00000005 00000005 00008010 00000000 0 0 00008010

/* compile.f */
hw/br_pkg.sv
hw/br_cond_eval.sv
hw/br_target_gen.sv
hw/br_resolver.sv
hw/br_unit.sv
sim/br_unit_props.sv
sim/br_unit_tb.sv

/* Makefile */
TOP := br_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o br_sim
	./obj_dir/br_sim > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
